// ==== hdl/host_rx_pkg.sv ====
package host_rx_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////
  localparam int AXIL_DATA_BITS = 64;
  localparam int AXIL_ADDR_BITS = 7;
  localparam int VADDR_BITS = 48;
  localparam int PID_BITS = 6;
  localparam int RING_IDX_BITS = 16;
  localparam int PKT_LEN_BITS = 32;

  // Register index field sits above the byte offset
  localparam int REG_IDX_BITS = AXIL_ADDR_BITS - $clog2(AXIL_DATA_BITS / 8);

  ////////////////////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////////////////////
  localparam logic [REG_IDX_BITS-1:0] REG_PID = 0;
  localparam logic [REG_IDX_BITS-1:0] REG_BUFF_ADDR = 1;
  localparam logic [REG_IDX_BITS-1:0] REG_BUFF_STRIDE = 2;
  localparam logic [REG_IDX_BITS-1:0] REG_RING_SIZE = 3;
  localparam logic [REG_IDX_BITS-1:0] REG_META_ADDR = 4;
  localparam logic [REG_IDX_BITS-1:0] REG_META_STRIDE = 5;
  localparam logic [REG_IDX_BITS-1:0] REG_RING_TAIL = 6;
  localparam logic [REG_IDX_BITS-1:0] REG_RING_HEAD = 7;
  localparam logic [REG_IDX_BITS-1:0] REG_IRQ_COALESCE = 8;

  // Per-packet sequencing
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    DATA_WR = 2'd1,
    META_WR = 2'd2,
    COMMIT  = 2'd3
  } rx_state_t;

  // Metadata word as written to the host, or as its fields
  typedef union packed {
    logic [63:0] raw;
    struct packed {
      logic [31:0] len;
      logic [15:0] seq;
      logic [7:0]  flags;
      logic [7:0]  idx;
    } fields;
  } rx_meta_u;

endpackage

// ==== hdl/host_rx_ctrl_regs.sv ====
`timescale 1ns/1ps

module host_rx_ctrl_regs (
  input  logic                                      aclk,
  input  logic                                      aresetn,

  input  logic [host_rx_pkg::AXIL_ADDR_BITS-1:0]    awaddr,
  input  logic                                      awvalid,
  output logic                                      awready,
  input  logic [host_rx_pkg::AXIL_DATA_BITS-1:0]    wdata,
  input  logic [host_rx_pkg::AXIL_DATA_BITS/8-1:0]  wstrb,
  input  logic                                      wvalid,
  output logic                                      wready,
  output logic [1:0]                                bresp,
  output logic                                      bvalid,
  input  logic                                      bready,
  input  logic [host_rx_pkg::AXIL_ADDR_BITS-1:0]    araddr,
  input  logic                                      arvalid,
  output logic                                      arready,
  output logic [host_rx_pkg::AXIL_DATA_BITS-1:0]    rdata,
  output logic [1:0]                                rresp,
  output logic                                      rvalid,
  input  logic                                      rready,

  input  logic [host_rx_pkg::RING_IDX_BITS-1:0]     ring_tail,

  output logic [host_rx_pkg::PID_BITS-1:0]          pid,
  output logic [host_rx_pkg::VADDR_BITS-1:0]        buff_addr,
  output logic [host_rx_pkg::VADDR_BITS-1:0]        buff_stride,
  output logic [host_rx_pkg::RING_IDX_BITS-1:0]     ring_size,
  output logic [host_rx_pkg::VADDR_BITS-1:0]        meta_addr,
  output logic [host_rx_pkg::VADDR_BITS-1:0]        meta_stride,
  output logic [host_rx_pkg::RING_IDX_BITS-1:0]     ring_head,
  output logic [31:0]                               irq_coalesce
);

  localparam int DW = host_rx_pkg::AXIL_DATA_BITS;
  localparam int SW = DW / 8;
  localparam int IW = host_rx_pkg::REG_IDX_BITS;
  localparam int AW = host_rx_pkg::AXIL_ADDR_BITS;
  localparam int VW = host_rx_pkg::VADDR_BITS;
  localparam int PW = host_rx_pkg::PID_BITS;
  localparam int RW = host_rx_pkg::RING_IDX_BITS;

  logic [IW-1:0] wr_idx;
  logic [IW-1:0] rd_idx;
  logic          aw_en;
  logic          wr_en;
  logic          rd_en;
  logic [DW-1:0] wmask;

  // Responses are always OKAY
  assign bresp = 2'b00;
  assign rresp = 2'b00;

  ////////////////////////////////////////////////////////////////////////////
  // Write channel
  ////////////////////////////////////////////////////////////////////////////
  // Address and data accepted together, one write outstanding
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      aw_en   <= 1'b1;
    end else begin
      if (!awready && awvalid && wvalid && aw_en) begin
        awready <= 1'b1;
        wready  <= 1'b1;
        aw_en   <= 1'b0;
      end else begin
        awready <= 1'b0;
        wready  <= 1'b0;
        if (bvalid && bready) begin
          aw_en <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (!awready && awvalid && wvalid && aw_en) begin
      wr_idx <= awaddr[AW-1:AW-IW];
    end
  end

  assign wr_en = awready && awvalid && wready && wvalid;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      bvalid <= 1'b0;
    end else if (wr_en && !bvalid) begin
      bvalid <= 1'b1;
    end else if (bvalid && bready) begin
      bvalid <= 1'b0;
    end
  end

  // Byte lanes expanded to a bit mask
  always_comb begin
    for (int i = 0; i < SW; i++) begin
      wmask[i*8 +: 8] = {8{wstrb[i]}};
    end
  end

  function automatic logic [DW-1:0] merged(input logic [DW-1:0] cur);
    return (cur & ~wmask) | (wdata & wmask);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      pid          <= '0;
      buff_addr    <= '0;
      buff_stride  <= '0;
      ring_size    <= '0;
      meta_addr    <= '0;
      meta_stride  <= '0;
      ring_head    <= '0;
      irq_coalesce <= '0;
    end else if (wr_en) begin
      case (wr_idx)
        host_rx_pkg::REG_PID:          pid <= PW'(merged(DW'(pid)));
        host_rx_pkg::REG_BUFF_ADDR:    buff_addr <= VW'(merged(DW'(buff_addr)));
        host_rx_pkg::REG_BUFF_STRIDE:  buff_stride <= VW'(merged(DW'(buff_stride)));
        host_rx_pkg::REG_RING_SIZE:    ring_size <= RW'(merged(DW'(ring_size)));
        host_rx_pkg::REG_META_ADDR:    meta_addr <= VW'(merged(DW'(meta_addr)));
        host_rx_pkg::REG_META_STRIDE:  meta_stride <= VW'(merged(DW'(meta_stride)));
        host_rx_pkg::REG_RING_HEAD:    ring_head <= RW'(merged(DW'(ring_head)));
        host_rx_pkg::REG_IRQ_COALESCE: irq_coalesce <= 32'(merged(DW'(irq_coalesce)));
        // Tail is owned by hardware
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read channel
  ////////////////////////////////////////////////////////////////////////////
  // No new address while a read response is still held
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      arready <= 1'b0;
    end else begin
      arready <= !arready && arvalid && !rvalid;
    end
  end

  always_ff @(posedge aclk) begin
    if (!arready && arvalid && !rvalid) begin
      rd_idx <= araddr[AW-1:AW-IW];
    end
  end

  assign rd_en = arready && arvalid && !rvalid;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rvalid <= 1'b0;
    end else if (rd_en) begin
      rvalid <= 1'b1;
    end else if (rvalid && rready) begin
      rvalid <= 1'b0;
    end
  end

  // Only the tail reads back
  always_ff @(posedge aclk) begin
    if (rd_en) begin
      rdata <= (rd_idx == host_rx_pkg::REG_RING_TAIL) ? DW'(ring_tail) : '0;
    end
  end

endmodule

// ==== hdl/host_rx_fsm.sv ====
`timescale 1ns/1ps

module host_rx_fsm (
  input  logic                   aclk,
  input  logic                   aresetn,
  input  logic                   pkt_valid,
  input  logic                   ring_full,
  input  logic                   wr_done,
  output logic                   rx_idle,
  output logic                   pkt_drop,
  output logic                   dma_wr_valid,
  output logic                   meta_wr_valid,
  output logic                   commit,
  output host_rx_pkg::rx_state_t state
);

  ////////////////////////////////////////////////////////////////////////////
  // State and request strobes
  ////////////////////////////////////////////////////////////////////////////
  // Strobes are registered so each fires once on entry to its state
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state         <= host_rx_pkg::IDLE;
      pkt_drop      <= 1'b0;
      dma_wr_valid  <= 1'b0;
      meta_wr_valid <= 1'b0;
    end else begin
      pkt_drop      <= 1'b0;
      dma_wr_valid  <= 1'b0;
      meta_wr_valid <= 1'b0;

      case (state)
        host_rx_pkg::IDLE: begin
          if (pkt_valid) begin
            if (ring_full) begin
              // No free slot, refuse and stay
              pkt_drop <= 1'b1;
            end else begin
              dma_wr_valid <= 1'b1;
              state        <= host_rx_pkg::DATA_WR;
            end
          end
        end

        host_rx_pkg::DATA_WR: begin
          if (wr_done) begin
            meta_wr_valid <= 1'b1;
            state         <= host_rx_pkg::META_WR;
          end
        end

        host_rx_pkg::META_WR: begin
          if (wr_done) begin
            state <= host_rx_pkg::COMMIT;
          end
        end

        // Single cycle, tail moves at its end
        host_rx_pkg::COMMIT: begin
          state <= host_rx_pkg::IDLE;
        end

        default: begin
          state <= host_rx_pkg::IDLE;
        end
      endcase
    end
  end

  assign rx_idle = (state == host_rx_pkg::IDLE);
  assign commit  = (state == host_rx_pkg::COMMIT);

endmodule

// ==== hdl/host_rx_slot_gen.sv ====
`timescale 1ns/1ps

module host_rx_slot_gen (
  input  logic                                  aclk,
  input  logic                                  aresetn,
  input  logic                                  pkt_valid,
  input  logic [host_rx_pkg::PKT_LEN_BITS-1:0]  pkt_len,
  input  logic [7:0]                            pkt_flags,
  input  logic                                  commit,
  input  logic [host_rx_pkg::RING_IDX_BITS-1:0] ring_size,
  input  logic [host_rx_pkg::RING_IDX_BITS-1:0] ring_head,
  input  logic [host_rx_pkg::VADDR_BITS-1:0]    buff_addr,
  input  logic [host_rx_pkg::VADDR_BITS-1:0]    buff_stride,
  input  logic [host_rx_pkg::VADDR_BITS-1:0]    meta_addr,
  input  logic [host_rx_pkg::VADDR_BITS-1:0]    meta_stride,
  output logic [host_rx_pkg::RING_IDX_BITS-1:0] ring_tail,
  output logic                                  ring_full,
  output logic [host_rx_pkg::VADDR_BITS-1:0]    dma_wr_addr,
  output logic [host_rx_pkg::PKT_LEN_BITS-1:0]  dma_wr_len,
  output logic [host_rx_pkg::VADDR_BITS-1:0]    meta_wr_addr,
  output logic [63:0]                           meta_wr_data
);

  localparam int RW = host_rx_pkg::RING_IDX_BITS;
  localparam int VW = host_rx_pkg::VADDR_BITS;

  logic [RW-1:0]         next_tail;
  logic [RW:0]           tail_inc;
  logic [15:0]           seq;
  logic [7:0]            flags_q;
  host_rx_pkg::rx_meta_u meta;

  // Extra bit keeps the compare safe at the top of the index range
  assign tail_inc  = {1'b0, ring_tail} + 1'b1;
  assign next_tail = (tail_inc >= {1'b0, ring_size}) ? '0 : tail_inc[RW-1:0];
  assign ring_full = (ring_size == '0) || (next_tail == ring_head);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      ring_tail <= '0;
      seq       <= '0;
    end else if (commit) begin
      ring_tail <= next_tail;
      seq       <= seq + 1'b1;
    end
  end

  // Notice payload held for the whole packet
  always_ff @(posedge aclk) begin
    if (pkt_valid && !ring_full) begin
      dma_wr_len <= pkt_len;
      flags_q    <= pkt_flags;
    end
  end

  assign dma_wr_addr  = buff_addr + VW'(ring_tail) * buff_stride;
  assign meta_wr_addr = meta_addr + VW'(ring_tail) * meta_stride;

  always_comb begin
    meta.fields.len   = dma_wr_len;
    meta.fields.seq   = seq;
    meta.fields.flags = flags_q;
    meta.fields.idx   = ring_tail[7:0];
  end

  assign meta_wr_data = meta.raw;

endmodule

// ==== hdl/host_rx_irq_timer.sv ====
`timescale 1ns/1ps

module host_rx_irq_timer #(
  parameter int IRQ_TIMER_BITS = 16
) (
  input  logic        aclk,
  input  logic        aresetn,
  input  logic        commit,
  input  logic [31:0] irq_coalesce,
  output logic        irq
);

  logic [15:0]               threshold;
  logic [IRQ_TIMER_BITS-1:0] timeout;
  logic [15:0]               pend_cnt;
  logic [15:0]               cnt_next;
  logic [IRQ_TIMER_BITS-1:0] tmr;
  logic [IRQ_TIMER_BITS:0]   tmr_next;
  logic                      pending;
  logic                      count_fire;
  logic                      tmo_fire;

  assign threshold = irq_coalesce[15:0];
  assign timeout   = IRQ_TIMER_BITS'(irq_coalesce[31:16]);

  assign cnt_next = pend_cnt + 16'(commit);
  assign pending  = (pend_cnt != '0);
  assign tmr_next = {1'b0, tmr} + 1'b1;

  // Threshold of zero turns count interrupts off
  assign count_fire = commit && (threshold != '0) && (cnt_next >= threshold);
  // Timer only runs once a commit is pending
  assign tmo_fire   = pending && (timeout != '0) && (tmr_next >= {1'b0, timeout});

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      pend_cnt <= '0;
      tmr      <= '0;
      irq      <= 1'b0;
    end else begin
      irq <= count_fire || tmo_fire;
      if (count_fire || tmo_fire) begin
        pend_cnt <= '0;
        tmr      <= '0;
      end else begin
        pend_cnt <= cnt_next;
        if (pending) begin
          tmr <= tmr_next[IRQ_TIMER_BITS-1:0];
        end
      end
    end
  end

endmodule

// ==== hdl/host_rx_top.sv ====
`timescale 1ns/1ps

module host_rx_top #(
  parameter int IRQ_TIMER_BITS = 16
) (
  input  logic                                      aclk,
  input  logic                                      aresetn,

  input  logic [host_rx_pkg::AXIL_ADDR_BITS-1:0]    awaddr,
  input  logic                                      awvalid,
  output logic                                      awready,
  input  logic [host_rx_pkg::AXIL_DATA_BITS-1:0]    wdata,
  input  logic [host_rx_pkg::AXIL_DATA_BITS/8-1:0]  wstrb,
  input  logic                                      wvalid,
  output logic                                      wready,
  output logic [1:0]                                bresp,
  output logic                                      bvalid,
  input  logic                                      bready,
  input  logic [host_rx_pkg::AXIL_ADDR_BITS-1:0]    araddr,
  input  logic                                      arvalid,
  output logic                                      arready,
  output logic [host_rx_pkg::AXIL_DATA_BITS-1:0]    rdata,
  output logic [1:0]                                rresp,
  output logic                                      rvalid,
  input  logic                                      rready,

  input  logic                                      pkt_valid,
  input  logic [host_rx_pkg::PKT_LEN_BITS-1:0]      pkt_len,
  input  logic [7:0]                                pkt_flags,
  output logic                                      rx_idle,
  output logic                                      pkt_drop,

  output logic                                      dma_wr_valid,
  output logic [host_rx_pkg::VADDR_BITS-1:0]        dma_wr_addr,
  output logic [host_rx_pkg::PKT_LEN_BITS-1:0]      dma_wr_len,
  output logic                                      meta_wr_valid,
  output logic [host_rx_pkg::VADDR_BITS-1:0]        meta_wr_addr,
  output logic [63:0]                               meta_wr_data,
  input  logic                                      wr_done,

  output logic                                      irq,
  output logic [host_rx_pkg::PID_BITS-1:0]          host_networking_pid
);

  logic [host_rx_pkg::VADDR_BITS-1:0]    buff_addr;
  logic [host_rx_pkg::VADDR_BITS-1:0]    buff_stride;
  logic [host_rx_pkg::VADDR_BITS-1:0]    meta_addr;
  logic [host_rx_pkg::VADDR_BITS-1:0]    meta_stride;
  logic [host_rx_pkg::RING_IDX_BITS-1:0] ring_size;
  logic [host_rx_pkg::RING_IDX_BITS-1:0] ring_head;
  logic [host_rx_pkg::RING_IDX_BITS-1:0] ring_tail;
  logic [31:0]                           irq_coalesce;
  logic                                  ring_full;
  logic                                  commit;

  ////////////////////////////////////////////////////////////////////////////
  // Host control registers
  ////////////////////////////////////////////////////////////////////////////
  host_rx_ctrl_regs i_regs (
    .aclk, .aresetn,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .ring_tail,
    .pid (host_networking_pid),
    .buff_addr, .buff_stride, .ring_size, .meta_addr, .meta_stride,
    .ring_head, .irq_coalesce
  );

  ////////////////////////////////////////////////////////////////////////////
  // Packet path
  ////////////////////////////////////////////////////////////////////////////
  host_rx_fsm i_fsm (
    .aclk, .aresetn, .pkt_valid, .ring_full, .wr_done,
    .rx_idle, .pkt_drop, .dma_wr_valid, .meta_wr_valid, .commit,
    .state ()
  );

  host_rx_slot_gen i_slot (
    .aclk, .aresetn, .pkt_valid, .pkt_len, .pkt_flags, .commit,
    .ring_size, .ring_head, .buff_addr, .buff_stride, .meta_addr, .meta_stride,
    .ring_tail, .ring_full, .dma_wr_addr, .dma_wr_len, .meta_wr_addr, .meta_wr_data
  );

  // Interrupt coalescing
  host_rx_irq_timer #(
    .IRQ_TIMER_BITS (IRQ_TIMER_BITS)
  ) i_irq (
    .aclk, .aresetn, .commit, .irq_coalesce, .irq
  );

endmodule

// ==== sim/host_rx_sva.sv ====
`timescale 1ns/1ps

module host_rx_sva (
  input logic aclk,
  input logic aresetn,
  input logic pkt_valid,
  input logic rx_idle,
  input logic pkt_drop,
  input logic dma_wr_valid,
  input logic meta_wr_valid,
  input logic bvalid,
  input logic bready
);

  // Notices only arrive between packets
  pkt_only_when_idle: assert property (
    @(posedge aclk) disable iff (!aresetn) pkt_valid |-> rx_idle
  ) else $error("pkt_valid asserted while rx_idle is low");

  // At most one request or drop strobe per cycle
  strobes_exclusive: assert property (
    @(posedge aclk) disable iff (!aresetn)
      $onehot0({dma_wr_valid, meta_wr_valid, pkt_drop})
  ) else $error("Request and drop strobes overlap");

  bvalid_held: assert property (
    @(posedge aclk) disable iff (!aresetn) bvalid && !bready |=> bvalid
  ) else $error("bvalid dropped before bready");

endmodule

bind host_rx_top host_rx_sva i_sva (
  .aclk          (aclk),
  .aresetn       (aresetn),
  .pkt_valid     (pkt_valid),
  .rx_idle       (rx_idle),
  .pkt_drop      (pkt_drop),
  .dma_wr_valid  (dma_wr_valid),
  .meta_wr_valid (meta_wr_valid),
  .bvalid        (bvalid),
  .bready        (bready)
);

// ==== sim/host_rx_clkgen.sv ====
`timescale 1ns/1ps

module host_rx_clkgen (
  output logic aclk,
  output logic aresetn
);

  // 8 ns period
  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  // Reset held low over the first two rising edges
  initial begin
    aresetn = 1'b0;
    repeat (2) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;
  end

endmodule

// ==== sim/host_rx_tb.sv ====
`timescale 1ns/1ps

module host_rx_tb;

  localparam int AW = host_rx_pkg::AXIL_ADDR_BITS;
  localparam int DW = host_rx_pkg::AXIL_DATA_BITS;
  localparam int VW = host_rx_pkg::VADDR_BITS;
  localparam int TIMEOUT_CYCLES = 200;

  localparam logic [2:0] K_WRITE = 3'd0;
  localparam logic [2:0] K_READ  = 3'd1;
  localparam logic [2:0] K_HEAD  = 3'd2;
  localparam logic [2:0] K_PKT   = 3'd3;
  localparam logic [2:0] K_IDLE  = 3'd4;

  localparam int SEL_RESET   = 0;
  localparam int SEL_AWREADY = 1;
  localparam int SEL_BVALID  = 2;
  localparam int SEL_ARREADY = 3;
  localparam int SEL_RVALID  = 4;
  localparam int SEL_IDLE    = 5;

  // One table row; data is the length for packets and the cycle count for idle
  typedef struct packed {
    logic [2:0]  kind;
    logic [3:0]  idx;
    logic [63:0] data;
    logic [7:0]  strb;
    logic        accept;
  } step_t;

  logic                                     aclk;
  logic                                     aresetn;
  logic [AW-1:0]                            awaddr;
  logic                                     awvalid;
  logic                                     awready;
  logic [DW-1:0]                            wdata;
  logic [DW/8-1:0]                          wstrb;
  logic                                     wvalid;
  logic                                     wready;
  logic [1:0]                               bresp;
  logic                                     bvalid;
  logic                                     bready;
  logic [AW-1:0]                            araddr;
  logic                                     arvalid;
  logic                                     arready;
  logic [DW-1:0]                            rdata;
  logic [1:0]                               rresp;
  logic                                     rvalid;
  logic                                     rready;
  logic                                     pkt_valid;
  logic [host_rx_pkg::PKT_LEN_BITS-1:0]     pkt_len;
  logic [7:0]                               pkt_flags;
  logic                                     rx_idle;
  logic                                     pkt_drop;
  logic                                     dma_wr_valid;
  logic [VW-1:0]                            dma_wr_addr;
  logic [host_rx_pkg::PKT_LEN_BITS-1:0]     dma_wr_len;
  logic                                     meta_wr_valid;
  logic [VW-1:0]                            meta_wr_addr;
  logic [63:0]                              meta_wr_data;
  logic                                     wr_done;
  logic                                     irq;
  logic [host_rx_pkg::PID_BITS-1:0]         host_networking_pid;

  // Reference model state
  step_t       steps[$];
  logic [63:0] m_regs[16];
  logic [15:0] m_tail;
  logic [15:0] m_seq;
  int          m_pend;
  int          exp_irq;
  int          irq_seen;
  int          checks;
  int          errors;

  host_rx_clkgen i_clk (.aclk, .aresetn);

  host_rx_top #(
    .IRQ_TIMER_BITS (16)
  ) i_dut (.*);

  always @(posedge aclk) begin
    if (!aresetn) begin
      irq_seen <= 0;
    end else if (irq) begin
      irq_seen <= irq_seen + 1;
    end
  end

  function automatic logic probe(input int sel);
    case (sel)
      SEL_RESET:   return aresetn;
      SEL_AWREADY: return awready;
      SEL_BVALID:  return bvalid;
      SEL_ARREADY: return arready;
      SEL_RVALID:  return rvalid;
      default:     return rx_idle;
    endcase
  endfunction

  // Writable bits of each register
  function automatic logic [63:0] field_mask(input logic [3:0] idx);
    case (idx)
      host_rx_pkg::REG_PID:          return 64'h3F;
      host_rx_pkg::REG_RING_SIZE,
      host_rx_pkg::REG_RING_HEAD:    return 64'hFFFF;
      host_rx_pkg::REG_IRQ_COALESCE: return 64'hFFFF_FFFF;
      host_rx_pkg::REG_BUFF_ADDR,
      host_rx_pkg::REG_BUFF_STRIDE,
      host_rx_pkg::REG_META_ADDR,
      host_rx_pkg::REG_META_STRIDE:  return 64'hFFFF_FFFF_FFFF;
      default:                       return 64'h0;
    endcase
  endfunction

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic wait_high(input int sel, input string what);
    int cnt;
    cnt = 0;
    while (probe(sel) !== 1'b1 && cnt < TIMEOUT_CYCLES) begin
      @(negedge aclk);
      cnt++;
    end
    if (probe(sel) !== 1'b1) begin
      errors++;
      $display("Timeout at %0t: %s never went high", $time, what);
    end
  endtask

  task automatic add_step(input logic [2:0] kind, input logic [3:0] idx,
                          input logic [63:0] data, input logic [7:0] strb,
                          input logic accept);
    step_t s;
    s.kind   = kind;
    s.idx    = idx;
    s.data   = data;
    s.strb   = strb;
    s.accept = accept;
    steps.push_back(s);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // AXI4-Lite master
  ////////////////////////////////////////////////////////////////////////////
  task automatic reg_write(input logic [3:0] idx, input logic [63:0] data,
                           input logic [7:0] strb);
    logic [63:0] bmask;
    for (int b = 0; b < 8; b++) begin
      bmask[b*8 +: 8] = {8{strb[b]}};
    end
    awaddr  = {idx, 3'b000};
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    wait_high(SEL_AWREADY, "awready");
    compare("wready", 64'(wready), 64'd1);
    @(negedge aclk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    wait_high(SEL_BVALID, "bvalid");
    compare("bresp", 64'(bresp), 64'd0);
    m_regs[idx] = ((m_regs[idx] & ~bmask) | (data & bmask)) & field_mask(idx);
    // Response held back for one cycle before it is taken
    @(negedge aclk);
    bready = 1'b1;
    @(negedge aclk);
    bready = 1'b0;
    compare("host_networking_pid", 64'(host_networking_pid),
            m_regs[host_rx_pkg::REG_PID]);
  endtask

  task automatic reg_read(input logic [3:0] idx);
    araddr  = {idx, 3'b000};
    arvalid = 1'b1;
    rready  = 1'b1;
    wait_high(SEL_ARREADY, "arready");
    @(negedge aclk);
    arvalid = 1'b0;
    wait_high(SEL_RVALID, "rvalid");
    compare("rresp", 64'(rresp), 64'd0);
    // Only the tail reads back
    compare("rdata", rdata, (idx == host_rx_pkg::REG_RING_TAIL) ? 64'(m_tail) : 64'd0);
    @(negedge aclk);
    rready = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Packet notice and write completions
  ////////////////////////////////////////////////////////////////////////////
  task automatic done_after_delay();
    int lat;
    lat = 1 + int'($urandom % 6);
    repeat (lat) @(negedge aclk);
    wr_done = 1'b1;
    @(negedge aclk);
    wr_done = 1'b0;
  endtask

  task automatic run_packet(input logic [31:0] len, input logic [7:0] flags,
                            input logic accept);
    logic [63:0] exp_meta;
    int          nxt;
    int          thr;
    wait_high(SEL_IDLE, "rx_idle before notice");
    pkt_valid = 1'b1;
    pkt_len   = len;
    pkt_flags = flags;
    @(negedge aclk);
    pkt_valid = 1'b0;
    compare("pkt_drop", 64'(pkt_drop), 64'(!accept));
    compare("dma_wr_valid", 64'(dma_wr_valid), 64'(accept));
    compare("rx_idle", 64'(rx_idle), 64'(!accept));
    if (accept) begin
      compare("dma_wr_addr", 64'(dma_wr_addr),
              (m_regs[host_rx_pkg::REG_BUFF_ADDR] +
               64'(m_tail) * m_regs[host_rx_pkg::REG_BUFF_STRIDE]) & 64'hFFFF_FFFF_FFFF);
      compare("dma_wr_len", 64'(dma_wr_len), 64'(len));
      done_after_delay();
      // Metadata holds length, sequence, flags and the low byte of the slot index
      exp_meta = {len, m_seq, flags, m_tail[7:0]};
      compare("meta_wr_valid", 64'(meta_wr_valid), 64'd1);
      compare("meta_wr_addr", 64'(meta_wr_addr),
              (m_regs[host_rx_pkg::REG_META_ADDR] +
               64'(m_tail) * m_regs[host_rx_pkg::REG_META_STRIDE]) & 64'hFFFF_FFFF_FFFF);
      compare("meta_wr_data", meta_wr_data, exp_meta);
      done_after_delay();
      wait_high(SEL_IDLE, "rx_idle after commit");
      nxt = int'(m_tail) + 1;
      if (nxt >= int'(m_regs[host_rx_pkg::REG_RING_SIZE][15:0])) begin
        nxt = 0;
      end
      m_tail = 16'(nxt);
      m_seq  = m_seq + 16'd1;
      m_pend++;
      thr = int'(m_regs[host_rx_pkg::REG_IRQ_COALESCE][15:0]);
      if (thr != 0 && m_pend >= thr) begin
        exp_irq++;
        m_pend = 0;
      end
    end
    @(negedge aclk);
    compare("irq count", 64'(irq_seen), 64'(exp_irq));
  endtask

  task automatic idle_wait(input int cycles);
    repeat (cycles) @(negedge aclk);
    // Pending commits with a timeout set have interrupted by now
    if (m_regs[host_rx_pkg::REG_IRQ_COALESCE][31:16] != 64'd0 && m_pend > 0) begin
      exp_irq++;
      m_pend = 0;
    end
    compare("irq count", 64'(irq_seen), 64'(exp_irq));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////////////////////
  task automatic build_table();
    // Every commit interrupts while the early checks run
    add_step(K_WRITE, host_rx_pkg::REG_IRQ_COALESCE, 64'h1, 8'hFF, 1'b0);
    add_step(K_WRITE, host_rx_pkg::REG_PID, 64'h2A, 8'h01, 1'b0);
    add_step(K_WRITE, host_rx_pkg::REG_PID, 64'hFF3F, 8'h02, 1'b0);
    add_step(K_WRITE, host_rx_pkg::REG_BUFF_ADDR, 64'h0000_1234_5678_9ABC, 8'hFF, 1'b0);
    add_step(K_WRITE, host_rx_pkg::REG_BUFF_ADDR, 64'hFFFF_FFFF_FFFF_DDEE, 8'h02, 1'b0);
    add_step(K_WRITE, host_rx_pkg::REG_BUFF_STRIDE, 64'h1000, 8'hFF, 1'b0);
    add_step(K_WRITE, host_rx_pkg::REG_BUFF_STRIDE, 64'h0002_0000, 8'h04, 1'b0);
    add_step(K_WRITE, host_rx_pkg::REG_RING_SIZE, 64'h4, 8'h03, 1'b0);
    add_step(K_WRITE, host_rx_pkg::REG_META_ADDR, 64'h8000_0000, 8'hFF, 1'b0);
    add_step(K_WRITE, host_rx_pkg::REG_META_STRIDE, 64'h10, 8'hFF, 1'b0);
    add_step(K_WRITE, host_rx_pkg::REG_RING_TAIL, 64'h5, 8'hFF, 1'b0);
    add_step(K_READ, host_rx_pkg::REG_RING_TAIL, 64'h0, 8'h00, 1'b0);
    add_step(K_READ, host_rx_pkg::REG_BUFF_ADDR, 64'h0, 8'h00, 1'b0);
    // Head at zero leaves room for three
    add_step(K_PKT, 4'd0, 64'd64, 8'h01, 1'b1);
    add_step(K_READ, host_rx_pkg::REG_RING_TAIL, 64'h0, 8'h00, 1'b0);
    add_step(K_PKT, 4'd0, 64'd1500, 8'h02, 1'b1);
    add_step(K_PKT, 4'd0, 64'd256, 8'h80, 1'b1);
    add_step(K_PKT, 4'd0, 64'd100, 8'h03, 1'b0);
    add_step(K_READ, host_rx_pkg::REG_RING_TAIL, 64'h0, 8'h00, 1'b0);
    add_step(K_HEAD, host_rx_pkg::REG_RING_HEAD, 64'h2, 8'hFF, 1'b0);
    add_step(K_PKT, 4'd0, 64'd128, 8'h04, 1'b1);
    add_step(K_PKT, 4'd0, 64'd512, 8'h05, 1'b1);
    add_step(K_PKT, 4'd0, 64'd77, 8'h06, 1'b0);
    add_step(K_READ, host_rx_pkg::REG_RING_TAIL, 64'h0, 8'h00, 1'b0);
    // Empty ring refuses everything
    add_step(K_WRITE, host_rx_pkg::REG_RING_SIZE, 64'h0, 8'hFF, 1'b0);
    add_step(K_PKT, 4'd0, 64'd60, 8'h07, 1'b0);
    add_step(K_WRITE, host_rx_pkg::REG_RING_SIZE, 64'h4, 8'hFF, 1'b0);
    add_step(K_HEAD, host_rx_pkg::REG_RING_HEAD, 64'h1, 8'hFF, 1'b0);
    // Count threshold of three over six commits
    add_step(K_WRITE, host_rx_pkg::REG_IRQ_COALESCE, 64'h3, 8'hFF, 1'b0);
    add_step(K_PKT, 4'd0, 64'd90, 8'h10, 1'b1);
    add_step(K_PKT, 4'd0, 64'd91, 8'h11, 1'b1);
    add_step(K_PKT, 4'd0, 64'd92, 8'h12, 1'b1);
    add_step(K_HEAD, host_rx_pkg::REG_RING_HEAD, 64'h0, 8'hFF, 1'b0);
    add_step(K_PKT, 4'd0, 64'd93, 8'h13, 1'b1);
    add_step(K_PKT, 4'd0, 64'd94, 8'h14, 1'b1);
    add_step(K_PKT, 4'd0, 64'd95, 8'h15, 1'b1);
    add_step(K_READ, host_rx_pkg::REG_RING_TAIL, 64'h0, 8'h00, 1'b0);
    // Timeout alone with a single commit
    add_step(K_HEAD, host_rx_pkg::REG_RING_HEAD, 64'h3, 8'hFF, 1'b0);
    add_step(K_WRITE, host_rx_pkg::REG_IRQ_COALESCE, 64'h0014_0000, 8'hFF, 1'b0);
    add_step(K_PKT, 4'd0, 64'd2048, 8'h20, 1'b1);
    add_step(K_IDLE, 4'd0, 64'd40, 8'h00, 1'b0);
    add_step(K_IDLE, 4'd0, 64'd40, 8'h00, 1'b0);
  endtask

  initial begin
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    pkt_valid = 1'b0;
    pkt_len   = '0;
    pkt_flags = '0;
    wr_done   = 1'b0;
    foreach (m_regs[i]) begin
      m_regs[i] = '0;
    end
    m_tail  = '0;
    m_seq   = '0;
    m_pend  = 0;
    exp_irq = 0;
    checks  = 0;
    errors  = 0;
    void'($urandom(24));
    build_table();

    wait_high(SEL_RESET, "aresetn");
    @(negedge aclk);

    foreach (steps[i]) begin
      case (steps[i].kind)
        K_WRITE, K_HEAD: reg_write(steps[i].idx, steps[i].data, steps[i].strb);
        K_READ:          reg_read(steps[i].idx);
        K_PKT:           run_packet(32'(steps[i].data), steps[i].strb, steps[i].accept);
        K_IDLE:          idle_wait(int'(steps[i].data));
        default:         ;
      endcase
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
hdl/host_rx_pkg.sv
hdl/host_rx_ctrl_regs.sv
hdl/host_rx_fsm.sv
hdl/host_rx_slot_gen.sv
hdl/host_rx_irq_timer.sv
hdl/host_rx_top.sv
sim/host_rx_sva.sv
sim/host_rx_clkgen.sv
sim/host_rx_tb.sv

// ==== Makefile ====
TOP = host_rx_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) \
		--Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "Testbench failed" sim.log; then exit 1; fi
	@grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
